/* rtl/align_flags.sv */
// ------------------------------------------------------------
// alignment flags g/wdt/wt, exponent range check and
// timed interrupt pulse
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "fpm_macros.svh"

module align_flags
	import fpm_pkg::*;
(
	input  logic   clk_0_f,
	input  logic   _0_f,
	input  fp_op_t op,
	input  logic   align,
	input  logic   check,
	exp_bus_if.dst eb,
	output logic   g,
	output logic   wdt,
	output logic   wt,
	output logic   ovf,
	output logic   unf,
	output logic   irq
);

	localparam int IRQ_W = $clog2(`FPM_IRQ_TICKS + 1);
	localparam logic signed [`FPM_EXP_W-1:0] EXP_MAX = `FPM_EXP_W'(127);
	localparam logic signed [`FPM_EXP_W-1:0] EXP_MIN = `FPM_EXP_W'(-128);

	logic signed [`FPM_EXP_W-1:0] d_s;
	logic                         chk;
	logic [IRQ_W-1:0]             irq_cnt;

	// ------------------------------------------------------------
	// alignment flags, af/sf only
	// ------------------------------------------------------------
	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			g   <= 1'b0;
			wdt <= 1'b0;
			wt  <= 1'b0;
		end else if (align && op.add_sub_float) begin
			g   <= eb.too_far;
			wdt <= eb.neg;
			// result stays in T when the other operand is far smaller
			wt  <= eb.too_far & ~eb.neg;
		end
	end

	// ------------------------------------------------------------
	// range check on the final exponent
	// ------------------------------------------------------------
	assign d_s = eb.d_ext;
	assign chk = check & op.is_float;
	assign ovf = chk & (d_s > EXP_MAX);
	assign unf = chk & (d_s < EXP_MIN);

	// pulse timer, restarted by each new detection
	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			irq_cnt <= '0;
		end else if (ovf || unf) begin
			irq_cnt <= IRQ_W'(`FPM_IRQ_TICKS);
		end else if (irq_cnt != '0) begin
			irq_cnt <= irq_cnt - 1'b1;
		end
	end

	assign irq = (irq_cnt != '0);

	a_wt_g: assert property (
		@(posedge clk_0_f) disable iff (_0_f)
		wt |-> g
	);

endmodule

/* rtl/exp_bus_if.sv */
// ------------------------------------------------------------
// adder results from the exponent path
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "fpm_macros.svh"

interface exp_bus_if;

	logic [`FPM_EXP_W-1:0] sum;
	logic                  neg;
	// magnitude of sum at or above the alignment limit
	logic                  too_far;
	logic [`FPM_FIC_W-1:0] shift;
	logic [`FPM_EXP_W-1:0] d_ext;

	modport src (output sum, neg, too_far, shift, d_ext);

	modport dst (input sum, neg, too_far, shift, d_ext);

endinterface

/* rtl/exp_path.sv */
// ------------------------------------------------------------
// exponent path: L mux, D and B registers, B bus modes,
// exponent adder and magnitude compare
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "fpm_macros.svh"

module exp_path (
	input  logic       clk_0_f,
	input  logic       _0_f,
	input  logic [7:0] w,
	input  logic       sel_w,
	input  logic       load_d,
	input  logic       clr_d,
	input  logic       load_b,
	input  logic [1:0] b_mode,
	input  logic       carry_in,
	output logic [7:0] d,
	exp_bus_if.src     eb
);

	logic [`FPM_EXP_W-1:0] l_bus;
	logic [`FPM_EXP_W-1:0] d_q;
	logic [7:0]            b_q;
	logic [7:0]            b_bus;
	logic [`FPM_EXP_W-1:0] sum;
	logic [`FPM_EXP_W-1:0] mag;

	// L: operand byte sign-extended, or the adder
	assign l_bus = sel_w ? {{(`FPM_EXP_W-8){w[7]}}, w} : sum;

	// ------------------------------------------------------------
	// D and B registers
	// ------------------------------------------------------------
	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			d_q <= '0;
		end else if (clr_d) begin
			d_q <= '0;
		end else if (load_d) begin
			d_q <= l_bus;
		end
	end

	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			b_q <= '0;
		end else if (load_b) begin
			b_q <= d_q[7:0];
		end
	end

	// ------------------------------------------------------------
	// B bus and adder
	// ------------------------------------------------------------
	always_comb begin
		case (b_mode)
			2'd0: b_bus = ~b_q;
			2'd1: b_bus = b_q;
			2'd2: b_bus = 8'hff;
			default: b_bus = 8'h00;
		endcase
	end

	assign sum = {{(`FPM_EXP_W-8){b_bus[7]}}, b_bus} + d_q
		+ {{(`FPM_EXP_W-1){1'b0}}, carry_in};

	// magnitude of the difference for alignment
	assign mag = sum[`FPM_EXP_W-1] ? (~sum + 1'b1) : sum;

	assign eb.sum     = sum;
	assign eb.neg     = sum[`FPM_EXP_W-1];
	assign eb.too_far = (mag >= `FPM_EXP_W'(`FPM_ALIGN_LIMIT));
	assign eb.shift   = mag[`FPM_FIC_W-1:0];
	assign eb.d_ext   = d_q;

	assign d = d_q[7:0];

	a_clr_load: assert property (
		@(posedge clk_0_f) disable iff (_0_f)
		!(clr_d && load_d)
	);

endmodule

/* rtl/fp_op_reg.sv */
// ------------------------------------------------------------
// operation register and opcode decoder
// ------------------------------------------------------------
`timescale 1ns/1ps

module fp_op_reg
	import fpm_pkg::*;
(
	input  logic       clk_0_f,
	input  logic       _0_f,
	input  logic       start,
	input  fp_opcode_e ir,
	output fp_op_t     op
);

	fp_opcode_e opc_q;
	logic       valid_q;

	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			opc_q   <= OP_AD;
			valid_q <= 1'b0;
		end else if (start) begin
			opc_q   <= ir;
			valid_q <= 1'b1;
		end
	end

	// decode from the stored opcode, all quiet until first start
	always_comb begin
		op.valid          = valid_q;
		op.onehot         = valid_q ? (8'b1 << opc_q) : 8'b0;
		op.is_float       = valid_q & opc_q[2];
		op.add_sub_float  = op.onehot[OP_AF] | op.onehot[OP_SF];
		op.mul_float_word = op.onehot[OP_MF] | op.onehot[OP_MW];
		op.div_float_word = op.onehot[OP_DF] | op.onehot[OP_DW];
		op.add_sub_fixed  = op.onehot[OP_AD] | op.onehot[OP_SD];
	end

	// exactly one operation selected while valid
	a_onehot: assert property (
		@(posedge clk_0_f) disable iff (_0_f)
		op.valid |-> $onehot(op.onehot)
	);

endmodule

/* rtl/fpm_macros.svh */
// ------------------------------------------------------------
// widths, step counts and interrupt pulse length for the
// floating-point exponent and sequencing unit
// ------------------------------------------------------------
`ifndef FPM_MACROS_SVH
`define FPM_MACROS_SVH

// 8 exponent bits plus two guard positions
`define FPM_EXP_W       10
`define FPM_FIC_W       6
// mantissa length, alignment limit
`define FPM_ALIGN_LIMIT 40

`define FPM_STEPS_MF    39
`define FPM_STEPS_DF    40
`define FPM_STEPS_MW    16
`define FPM_STEPS_DW    17

`define FPM_IRQ_TICKS   8

`endif

/* rtl/fpm_pkg.sv */
// ------------------------------------------------------------
// opcode encoding and decoded operation type
// ------------------------------------------------------------
package fpm_pkg;

	// top bit set means floating point
	typedef enum logic [2:0] {
		OP_AD = 3'd0,
		OP_SD = 3'd1,
		OP_MW = 3'd2,
		OP_DW = 3'd3,
		OP_AF = 3'd4,
		OP_SF = 3'd5,
		OP_MF = 3'd6,
		OP_DF = 3'd7
	} fp_opcode_e;

	// decoded operation, one-hot indexed by opcode value
	typedef struct packed {
		logic [7:0] onehot;
		logic       valid;
		logic       is_float;
		// af or sf
		logic       add_sub_float;
		// mf or mw
		logic       mul_float_word;
		// df or dw
		logic       div_float_word;
		// ad or sd
		logic       add_sub_fixed;
	} fp_op_t;

endpackage

/* rtl/fpm_top.sv */
// ------------------------------------------------------------
// top level of the exponent and sequencing unit
// ------------------------------------------------------------
`timescale 1ns/1ps

module fpm_top
	import fpm_pkg::*;
(
	input  logic       clk_0_f,
	input  logic       _0_f,
	input  logic       start,
	input  logic [2:0] ir,
	input  logic [7:0] w,
	input  logic       sel_w,
	input  logic       load_d,
	input  logic       clr_d,
	input  logic       load_b,
	input  logic [1:0] b_mode,
	input  logic       carry_in,
	input  logic       align,
	input  logic       md_start,
	input  logic       step,
	input  logic       check,
	output logic [7:0] d,
	output logic       is_float,
	output logic       g,
	output logic       wdt,
	output logic       wt,
	output logic       fic_zero,
	output logic       ovf,
	output logic       unf,
	output logic       irq
);

	fp_op_t op;

	exp_bus_if eb_i ();

	fp_op_reg op_reg_i (
		.clk_0_f (clk_0_f),
		._0_f    (_0_f),
		.start   (start),
		.ir      (fp_opcode_e'(ir)),
		.op      (op)
	);

	exp_path exp_path_i (
		.clk_0_f  (clk_0_f),
		._0_f     (_0_f),
		.w        (w),
		.sel_w    (sel_w),
		.load_d   (load_d),
		.clr_d    (clr_d),
		.load_b   (load_b),
		.b_mode   (b_mode),
		.carry_in (carry_in),
		.d        (d),
		.eb       (eb_i.src)
	);

	step_counter step_counter_i (
		.clk_0_f  (clk_0_f),
		._0_f     (_0_f),
		.op       (op),
		.align    (align),
		.md_start (md_start),
		.step     (step),
		.eb       (eb_i.dst),
		.fic_zero (fic_zero)
	);

	align_flags align_flags_i (
		.clk_0_f (clk_0_f),
		._0_f    (_0_f),
		.op      (op),
		.align   (align),
		.check   (check),
		.eb      (eb_i.dst),
		.g       (g),
		.wdt     (wdt),
		.wt      (wt),
		.ovf     (ovf),
		.unf     (unf),
		.irq     (irq)
	);

	assign is_float = op.is_float;

endmodule

/* rtl/step_counter.sv */
// ------------------------------------------------------------
// step counter for alignment shifts and mul/div steps
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "fpm_macros.svh"

module step_counter
	import fpm_pkg::*;
(
	input  logic   clk_0_f,
	input  logic   _0_f,
	input  fp_op_t op,
	input  logic   align,
	input  logic   md_start,
	input  logic   step,
	exp_bus_if.dst eb,
	output logic   fic_zero
);

	localparam logic [`FPM_FIC_W-1:0] STEPS_MF = `FPM_FIC_W'(`FPM_STEPS_MF);
	localparam logic [`FPM_FIC_W-1:0] STEPS_DF = `FPM_FIC_W'(`FPM_STEPS_DF);
	localparam logic [`FPM_FIC_W-1:0] STEPS_MW = `FPM_FIC_W'(`FPM_STEPS_MW);
	localparam logic [`FPM_FIC_W-1:0] STEPS_DW = `FPM_FIC_W'(`FPM_STEPS_DW);

	logic [`FPM_FIC_W-1:0] cnt_q;
	logic [`FPM_FIC_W-1:0] load_val;
	logic                  load_align;
	logic                  load_md;

	assign load_align = align & op.add_sub_float;
	assign load_md    = md_start & (op.mul_float_word | op.div_float_word);

	// alignment shift first, zero when it cannot be aligned
	always_comb begin
		load_val = '0;
		if (load_align) begin
			load_val = eb.too_far ? '0 : eb.shift;
		end else if (op.onehot[OP_MF]) begin
			load_val = STEPS_MF;
		end else if (op.onehot[OP_DF]) begin
			load_val = STEPS_DF;
		end else if (op.onehot[OP_MW]) begin
			load_val = STEPS_MW;
		end else if (op.onehot[OP_DW]) begin
			load_val = STEPS_DW;
		end
	end

	always_ff @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			cnt_q <= '0;
		end else if (load_align || load_md) begin
			cnt_q <= load_val;
		end else if (step && cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	assign fic_zero = (cnt_q == '0);

	// a step at zero holds, only a load leaves zero
	a_no_wrap: assert property (
		@(posedge clk_0_f) disable iff (_0_f)
		(fic_zero && !load_align && !load_md) |=> fic_zero
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --assert -f src.f --top-module fpm_tb -o fpm_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/fpm_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -q "=== PASS ===" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation did not pass, see $LOG"
exit 1

/* src.f */
+incdir+rtl
rtl/fpm_pkg.sv
rtl/exp_bus_if.sv
rtl/fp_op_reg.sv
rtl/exp_path.sv
rtl/step_counter.sv
rtl/align_flags.sv
rtl/fpm_top.sv
testbench/fpm_tb.sv

/* testbench/fpm_tb.sv */
// ------------------------------------------------------------
// testbench for the exponent and sequencing unit with stimulus,
// reference model and checking assertions
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "fpm_macros.svh"

module fpm_tb;

	// stimulus takes at most about 1100 cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic       clk_0_f;
	logic       _0_f;
	logic [2:0] ir;
	logic [7:0] w;
	logic [1:0] b_mode;
	logic       start, sel_w, load_d, clr_d, load_b, carry_in;
	logic       align, md_start, step, check;
	logic [7:0] d;
	logic       is_float, g, wdt, wt, fic_zero, ovf, unf, irq;

	// reference model state
	logic [9:0] m_d;
	logic [7:0] m_b;
	logic [5:0] m_cnt;
	logic [2:0] m_opc;
	logic       m_valid, m_g, m_wdt, m_wt;
	int         m_irq;
	logic [7:0] m_bbus;
	logic [9:0] m_sum;
	int         s_sum, s_d, m_mag;
	logic       m_far, m_float, m_asf, m_md, m_ovf, m_unf;
	int         cycles;

	fpm_top dut_i (.*);

	initial begin
		clk_0_f = 1'b0;
		forever #50 clk_0_f = ~clk_0_f;
	end

	function automatic int to_signed(input logic [9:0] v);
		return v[9] ? int'(v) - 1024 : int'(v);
	endfunction

	function automatic logic [5:0] steps_for(input logic [2:0] opc);
		case (opc)
			3'd2: return 6'(`FPM_STEPS_MW);
			3'd3: return 6'(`FPM_STEPS_DW);
			3'd6: return 6'(`FPM_STEPS_MF);
			3'd7: return 6'(`FPM_STEPS_DF);
			default: return 6'd0;
		endcase
	endfunction

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	always_comb begin
		case (b_mode)
			2'd0: m_bbus = ~m_b;
			2'd1: m_bbus = m_b;
			2'd2: m_bbus = 8'hff;
			default: m_bbus = 8'h00;
		endcase
		m_sum   = {{2{m_bbus[7]}}, m_bbus} + m_d + {9'd0, carry_in};
		s_sum   = to_signed(m_sum);
		s_d     = to_signed(m_d);
		m_mag   = (s_sum < 0) ? -s_sum : s_sum;
		m_far   = m_mag >= `FPM_ALIGN_LIMIT;
		m_float = m_valid & m_opc[2];
		m_asf   = m_valid && (m_opc == 3'd4 || m_opc == 3'd5);
		// mw, dw, mf, df all have bit 1 set
		m_md    = m_valid & m_opc[1];
		m_ovf   = check && m_float && s_d > 127;
		m_unf   = check && m_float && s_d < -128;
	end

	always @(posedge clk_0_f or posedge _0_f) begin
		if (_0_f) begin
			m_d <= '0;
			m_b <= '0;
			m_cnt <= '0;
			m_opc <= '0;
			m_valid <= 1'b0;
			m_g <= 1'b0;
			m_wdt <= 1'b0;
			m_wt <= 1'b0;
			m_irq <= 0;
		end else begin
			if (start) begin
				m_opc <= ir;
				m_valid <= 1'b1;
			end
			if (clr_d)
				m_d <= '0;
			else if (load_d)
				m_d <= sel_w ? {{2{w[7]}}, w} : m_sum;
			if (load_b)
				m_b <= m_d[7:0];
			if (align && m_asf) begin
				m_g <= m_far;
				m_wdt <= s_sum < 0;
				m_wt <= m_far && s_sum >= 0;
				m_cnt <= m_far ? 6'd0 : 6'(m_mag);
			end else if (md_start && m_md) begin
				m_cnt <= steps_for(m_opc);
			end else if (step && m_cnt != 0) begin
				m_cnt <= m_cnt - 6'd1;
			end
			if (m_ovf || m_unf)
				m_irq <= `FPM_IRQ_TICKS;
			else if (m_irq != 0)
				m_irq <= m_irq - 1;
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	task automatic fail_stop();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic value_fail(input string name, input logic [9:0] got, input logic [9:0] exp);
		$display("Fail %s: got %h expected %h", name, got, exp);
		fail_stop();
	endtask

	a_d: assert property (@(posedge clk_0_f) disable iff (_0_f) d == m_d[7:0])
		else value_fail("d", 10'($sampled(d)), 10'($sampled(m_d[7:0])));
	a_is_float: assert property (@(posedge clk_0_f) disable iff (_0_f) is_float == m_float)
		else value_fail("is_float", 10'($sampled(is_float)), 10'($sampled(m_float)));
	a_g: assert property (@(posedge clk_0_f) disable iff (_0_f) g == m_g)
		else value_fail("g", 10'($sampled(g)), 10'($sampled(m_g)));
	a_wdt: assert property (@(posedge clk_0_f) disable iff (_0_f) wdt == m_wdt)
		else value_fail("wdt", 10'($sampled(wdt)), 10'($sampled(m_wdt)));
	a_wt: assert property (@(posedge clk_0_f) disable iff (_0_f) wt == m_wt)
		else value_fail("wt", 10'($sampled(wt)), 10'($sampled(m_wt)));
	a_fic: assert property (@(posedge clk_0_f) disable iff (_0_f) fic_zero == (m_cnt == 0))
		else value_fail("fic_zero", 10'($sampled(fic_zero)), 10'($sampled(m_cnt == 0)));
	a_ovf: assert property (@(posedge clk_0_f) disable iff (_0_f) ovf == m_ovf)
		else value_fail("ovf", 10'($sampled(ovf)), 10'($sampled(m_ovf)));
	a_unf: assert property (@(posedge clk_0_f) disable iff (_0_f) unf == m_unf)
		else value_fail("unf", 10'($sampled(unf)), 10'($sampled(m_unf)));
	a_irq: assert property (@(posedge clk_0_f) disable iff (_0_f) irq == (m_irq != 0))
		else value_fail("irq", 10'($sampled(irq)), 10'($sampled(m_irq != 0)));

	always @(posedge clk_0_f) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the test sequence did not finish in time");
			fail_stop();
		end
	end

	// ------------------------------------------------------------
	// stimulus tasks start and end on a falling edge
	// ------------------------------------------------------------
	task automatic pulse_start(input logic [2:0] opc);
		ir = opc;
		start = 1'b1;
		@(negedge clk_0_f);
		start = 1'b0;
	endtask

	task automatic load_byte(input logic [7:0] v);
		w = v;
		sel_w = 1'b1;
		load_d = 1'b1;
		@(negedge clk_0_f);
		sel_w = 1'b0;
		load_d = 1'b0;
	endtask

	task automatic copy_b();
		load_b = 1'b1;
		@(negedge clk_0_f);
		load_b = 1'b0;
	endtask

	task automatic add_into_d(input logic [1:0] mode, input logic cin);
		b_mode = mode;
		carry_in = cin;
		load_d = 1'b1;
		@(negedge clk_0_f);
		load_d = 1'b0;
	endtask

	// difference a - b on the adder followed by one align strobe
	task automatic do_align(input logic [7:0] a, input logic [7:0] b);
		load_byte(b);
		copy_b();
		load_byte(a);
		b_mode = 2'd0;
		carry_in = 1'b1;
		align = 1'b1;
		@(negedge clk_0_f);
		align = 1'b0;
	endtask

	// step until the counter reports zero and a few steps beyond
	task automatic run_steps();
		step = 1'b1;
		while (!fic_zero)
			@(negedge clk_0_f);
		repeat (3) @(negedge clk_0_f);
		step = 1'b0;
	endtask

	task automatic range_check(input logic [7:0] a, input logic [1:0] mode, input logic cin);
		load_byte(a);
		add_into_d(mode, cin);
		check = 1'b1;
		@(negedge clk_0_f);
		check = 1'b0;
		while (irq)
			@(negedge clk_0_f);
	endtask

	initial begin
		void'($urandom(32'hcde1_d394));
		cycles = 0;
		{start, sel_w, load_d, clr_d, load_b, carry_in} = '0;
		{align, md_start, step, check} = '0;
		ir = '0;
		w = '0;
		b_mode = '0;
		_0_f = 1'b1;
		repeat (8) @(negedge clk_0_f);
		_0_f = 1'b0;
		@(negedge clk_0_f);

		for (int i = 0; i < 8; i++)
			pulse_start(3'(i));

		// random operands through every mode and both carries
		for (int i = 0; i < 40; i++) begin
			load_byte(8'($urandom));
			copy_b();
			load_byte(8'($urandom));
			add_into_d(2'(i), 1'(i >> 2));
		end
		clr_d = 1'b1;
		@(negedge clk_0_f);
		clr_d = 1'b0;

		// alignment edges and random differences
		pulse_start(3'd4);
		do_align(8'd39, 8'd0);
		run_steps();
		do_align(8'd40, 8'd0);
		run_steps();
		do_align(8'd0, 8'd39);
		run_steps();
		do_align(8'd0, 8'd40);
		run_steps();
		pulse_start(3'd5);
		repeat (12) begin
			do_align(8'($urandom), 8'($urandom));
			run_steps();
		end
		// small positive difference leaves the flags low
		do_align(8'd20, 8'd15);
		run_steps();
		pulse_start(3'd0);
		do_align(8'd0, 8'd100);

		// multiply and divide step counts
		for (int i = 0; i < 4; i++) begin
			pulse_start(i < 2 ? 3'(6 + i) : 3'(i));
			md_start = 1'b1;
			@(negedge clk_0_f);
			md_start = 1'b0;
			run_steps();
		end

		// range edges 127, 128, -128, -129
		pulse_start(3'd4);
		range_check(8'd127, 2'd3, 1'b0);
		range_check(8'd127, 2'd3, 1'b1);
		range_check(8'h80, 2'd3, 1'b0);
		range_check(8'h80, 2'd2, 1'b0);
		pulse_start(3'd1);
		range_check(8'd127, 2'd3, 1'b1);
		range_check(8'h80, 2'd2, 1'b0);

		repeat (2) @(negedge clk_0_f);
		$display("=== PASS ===");
		$finish;
	end

endmodule
